// ==== src.f ====
+incdir+source
source/drive_pkg.sv
source/drive_stream_if.sv
source/drive_ingress.sv
source/drive_modulator.sv
source/pwm_bank.sv
source/phased_array_drive.sv
test/tb_phased_array_drive.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for failure.
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_phased_array_drive \
  > build.log 2>&1 &&
  ./obj_dir/Vtb_phased_array_drive > sim.log 2>&1 ||
  { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -F -q "*** TEST FAILED ***" sim.log &&
  { echo "Simulation reported failure, see sim.log"; exit 1; }

echo "Simulation finished without failure"
exit 0

// ==== test/tb_phased_array_drive.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "drive_macros.svh"

module tb_phased_array_drive;

  localparam int num_frames   = 12;
  localparam int run_limit_ns = 40 * 256 * 24;

  logic                     clk;
  logic                     rst_n;
  logic                     din_valid;
  logic [`DRIVE_DATA_W-1:0] din_intensity;
  logic [`DRIVE_DATA_W-1:0] din_phase;
  logic                     credit_return;
  logic [`DRIVE_DATA_W-1:0] mod_value;
  logic [`DRIVE_NUM_CH-1:0] pwm_out;
  logic [`DRIVE_DATA_W-1:0] time_cnt;

  // Reference model state with staged and active copies per channel.
  int stg_pw [`DRIVE_NUM_CH];
  int stg_ph [`DRIVE_NUM_CH];
  int act_pw [`DRIVE_NUM_CH];
  int act_ph [`DRIVE_NUM_CH];
  int high_cnt [`DRIVE_NUM_CH];

  int credits = `DRIVE_FIFO_DEPTH;
  int arrivals = 0;
  int exp_time = 0;
  int obs_time = 0;
  int frames_seen = 0;
  int cycle_checks = 0;
  int frame_checks = 0;
  int errors = 0;
  int timeouts = 0;

  phased_array_drive uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .din_valid    (din_valid),
    .din_intensity(din_intensity),
    .din_phase    (din_phase),
    .credit_return(credit_return),
    .mod_value    (mod_value),
    .pwm_out      (pwm_out),
    .time_cnt     (time_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pulse rule
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic int pulse_width_of(input int intensity, input int level);
    return (intensity * level) >> 9;
  endfunction

  function automatic logic expected_out(input int t, input int pw, input int ph);
    int rise;
    rise = (ph - pw / 2) & 255;
    return ((t - rise) & 255) < pw;
  endfunction

  task automatic finish_run();
    $display("Summary: %0d cycle checks, %0d frame checks, %0d errors, %0d timeouts",
             cycle_checks, frame_checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output monitor
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Outputs are sampled on the falling edge, half a cycle after the DUT updates them.
  always @(negedge clk) begin
    if (rst_n) begin
      if (int'(time_cnt) != exp_time) begin
        $display("error: %0t ns: time_cnt is %0d, expected %0d", $time, time_cnt, exp_time);
        errors++;
      end
      obs_time = int'(time_cnt);
      exp_time = (obs_time + 1) % 256;
      if (credit_return === 1'b1) begin
        credits++;
      end
      if (credits < 0 || credits > `DRIVE_FIFO_DEPTH) begin
        $display("error: %0t ns: host credit count is %0d", $time, credits);
        errors++;
      end
      if (obs_time == 0) begin
        for (int ch = 0; ch < `DRIVE_NUM_CH; ch++) begin
          if (frames_seen > 0) begin
            frame_checks++;
            if (high_cnt[ch] != act_pw[ch]) begin
              $display("error: %0t ns: channel %0d was high %0d cycles, expected %0d",
                       $time, ch, high_cnt[ch], act_pw[ch]);
              errors++;
            end
          end
          high_cnt[ch] = 0;
          act_pw[ch] = stg_pw[ch];
          act_ph[ch] = stg_ph[ch];
        end
        frames_seen++;
      end
      for (int ch = 0; ch < `DRIVE_NUM_CH; ch++) begin
        cycle_checks++;
        if (pwm_out[ch] !== expected_out(obs_time, act_pw[ch], act_ph[ch])) begin
          $display("error: %0t ns: pwm_out[%0d] is %b at time_cnt %0d", $time, ch,
                   pwm_out[ch], obs_time);
          errors++;
        end
        if (pwm_out[ch] === 1'b1) begin
          high_cnt[ch]++;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Host side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic wait_credits_full();
    int n;
    n = 0;
    @(posedge clk);
    while (credits != `DRIVE_FIFO_DEPTH) begin
      n++;
      if (n > 64) begin
        $display("Host credits did not return within 64 cycles, %0d held", credits);
        timeouts++;
        finish_run();
      end
      @(posedge clk);
    end
  endtask

  task automatic wait_send_window();
    int n;
    n = 0;
    @(posedge clk);
    while (obs_time < 8 || obs_time > 240) begin
      n++;
      if (n > 300) begin
        $display("The time counter never entered the send window");
        timeouts++;
        finish_run();
      end
      @(posedge clk);
    end
  endtask

  task automatic wait_frame_start();
    int n;
    n = 0;
    @(posedge clk);
    while (obs_time != 0) begin
      n++;
      if (n > 300) begin
        $display("The time counter did not wrap within 300 cycles");
        timeouts++;
        finish_run();
      end
      @(posedge clk);
    end
  endtask

  // Sends back-to-back entries, one per cycle, and each one spends a credit.
  task automatic send_burst(input int count);
    int intensity;
    int phase;
    int ch;
    for (int k = 0; k < count; k++) begin
      @(posedge clk);
      intensity = int'($urandom % 256);
      phase = int'($urandom % 256);
      ch = arrivals % `DRIVE_NUM_CH;
      din_valid <= 1'b1;
      din_intensity <= 8'(intensity);
      din_phase <= 8'(phase);
      credits--;
      stg_pw[ch] = pulse_width_of(intensity, int'(mod_value));
      stg_ph[ch] = phase;
      arrivals++;
    end
    @(posedge clk);
    din_valid <= 1'b0;
  endtask

  initial begin
    #(run_limit_ns);
    $display("Simulation time limit reached before the test completed");
    timeouts++;
    finish_run();
  end

  initial begin
    int left;
    int size;
    void'($urandom(32'h30254b40));
    rst_n = 1'b0;
    din_valid = 1'b0;
    din_intensity = '0;
    din_phase = '0;
    mod_value = 8'd255;
    repeat (15) @(posedge clk);
    @(negedge clk);
    if (pwm_out !== '0 || credit_return !== 1'b0 || time_cnt !== '0) begin
      $display("error: %0t ns: outputs not cleared by reset", $time);
      errors++;
    end
    @(posedge clk);
    rst_n <= 1'b1;

    for (int f = 0; f < num_frames; f++) begin
      wait_credits_full();
      // Every third frame takes a new modulation level and refreshes all channels.
      if (f % 3 == 0) begin
        @(posedge clk);
        case (f / 3)
          0: mod_value <= 8'd255;
          1: mod_value <= 8'd0;
          2: mod_value <= 8'd128;
          default: mod_value <= 8'($urandom);
        endcase
        left = `DRIVE_NUM_CH;
      end else begin
        left = 3 + int'($urandom % 10);
      end
      while (left > 0) begin
        size = (left > `DRIVE_FIFO_DEPTH) ? `DRIVE_FIFO_DEPTH : left;
        wait_credits_full();
        wait_send_window();
        send_burst(size);
        left -= size;
      end
      wait_frame_start();
    end
    wait_frame_start();
    wait_frame_start();
    finish_run();
  end

endmodule

`default_nettype wire

// ==== source/phased_array_drive.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "drive_macros.svh"

module phased_array_drive (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     din_valid,
  input  logic [`DRIVE_DATA_W-1:0] din_intensity,
  input  logic [`DRIVE_DATA_W-1:0] din_phase,
  output logic                     credit_return,
  input  logic [`DRIVE_DATA_W-1:0] mod_value,
  output logic [`DRIVE_NUM_CH-1:0] pwm_out,
  output logic [`DRIVE_DATA_W-1:0] time_cnt
);

  drive_stream_if #(
    .payload_t(drive_pkg::drive_entry_t)
  ) stage_a ();

  drive_stream_if #(
    .payload_t(drive_pkg::pwm_entry_t)
  ) stage_b ();

  drive_pkg::drive_entry_t din_entry;

  assign din_entry.intensity = din_intensity;
  assign din_entry.phase     = din_phase;

  drive_ingress drive_ingress (
    .clk          (clk),
    .rst_n        (rst_n),
    .din_valid    (din_valid),
    .din_entry    (din_entry),
    .credit_return(credit_return),
    .stage_a      (stage_a.source)
  );

  drive_modulator drive_modulator (
    .clk      (clk),
    .rst_n    (rst_n),
    .mod_value(mod_value),
    .stage_a  (stage_a.sink),
    .stage_b  (stage_b.source)
  );

  pwm_bank pwm_bank (
    .clk     (clk),
    .rst_n   (rst_n),
    .stage_b (stage_b.sink),
    .time_cnt(time_cnt),
    .pwm_out (pwm_out)
  );

endmodule

`default_nettype wire

// ==== source/pwm_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "drive_macros.svh"

module pwm_bank (
  input  logic                     clk,
  input  logic                     rst_n,
  drive_stream_if.sink             stage_b,
  output logic [`DRIVE_DATA_W-1:0] time_cnt,
  output logic [`DRIVE_NUM_CH-1:0] pwm_out
);

  // Staged entries collect the next frame, active entries drive the outputs.
  drive_pkg::pwm_entry_t staged [`DRIVE_NUM_CH];
  drive_pkg::pwm_entry_t active [`DRIVE_NUM_CH];

  logic [`DRIVE_DATA_W-1:0] time_next;
  logic                     frame_wrap;
  drive_pkg::pwm_entry_t    active_next [`DRIVE_NUM_CH];
  logic [`DRIVE_DATA_W-1:0] rise [`DRIVE_NUM_CH];
  logic [`DRIVE_DATA_W-1:0] offset [`DRIVE_NUM_CH];
  logic [`DRIVE_NUM_CH-1:0] pwm_next;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Comparators
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The outputs are registered, so they are worked out from the values that
  // time_cnt and the active entries take at the coming edge.
  always_comb begin
    time_next  = time_cnt + 1'b1;
    frame_wrap = (time_cnt == '1);
    for (int i = 0; i < `DRIVE_NUM_CH; i++) begin
      active_next[i] = frame_wrap ? staged[i] : active[i];
      // The pulse is centred on the phase and all math is modulo 256.
      rise[i]        = active_next[i].phase - (active_next[i].pulse_width >> 1);
      offset[i]      = time_next - rise[i];
      pwm_next[i]    = (offset[i] < active_next[i].pulse_width);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Time base and registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      time_cnt <= '0;
      pwm_out  <= '0;
    end else begin
      time_cnt <= time_next;
      pwm_out  <= pwm_next;
    end
  end

  // An entry landing on the wrap edge goes to the staged copy only and
  // becomes active one frame later.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `DRIVE_NUM_CH; i++) begin
        staged[i] <= '0;
        active[i] <= '0;
      end
    end else begin
      if (frame_wrap) begin
        for (int i = 0; i < `DRIVE_NUM_CH; i++) begin
          active[i] <= staged[i];
        end
      end
      if (stage_b.valid) begin
        staged[stage_b.channel] <= stage_b.entry;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/drive_modulator.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "drive_macros.svh"

module drive_modulator (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [`DRIVE_DATA_W-1:0] mod_value,
  drive_stream_if.sink             stage_a,
  drive_stream_if.source           stage_b
);

  // Dropping 9 bits of the 16-bit product leaves a width of 0 to 127.
  localparam int pw_shift = 9;

  logic [2*`DRIVE_DATA_W-1:0] s1_product;
  logic [`DRIVE_DATA_W-1:0]   s1_phase;
  logic [`DRIVE_CH_W-1:0]     s1_channel;
  logic                       s1_valid;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage 1 modulation product
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid   <= 1'b0;
      s1_product <= '0;
      s1_phase   <= '0;
      s1_channel <= '0;
    end else begin
      s1_valid   <= stage_a.valid;
      s1_product <= stage_a.entry.intensity * mod_value;
      s1_phase   <= stage_a.entry.phase;
      s1_channel <= stage_a.channel;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage 2 pulse width encode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage_b.valid   <= 1'b0;
      stage_b.channel <= '0;
      stage_b.entry   <= '0;
    end else begin
      stage_b.valid             <= s1_valid;
      stage_b.channel           <= s1_channel;
      stage_b.entry.pulse_width <= `DRIVE_DATA_W'(s1_product >> pw_shift);
      stage_b.entry.phase       <= s1_phase;
    end
  end

endmodule

`default_nettype wire

// ==== source/drive_ingress.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "drive_macros.svh"

module drive_ingress (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 din_valid,
  input  drive_pkg::drive_entry_t din_entry,
  output logic                 credit_return,
  drive_stream_if.source       stage_a
);

  localparam int ptr_w = $clog2(`DRIVE_FIFO_DEPTH);

  drive_pkg::drive_entry_t fifo_mem [`DRIVE_FIFO_DEPTH];

  // One extra bit on each pointer tells full from empty.
  logic [ptr_w:0]         wr_ptr;
  logic [ptr_w:0]         rd_ptr;
  logic                   fifo_empty;
  logic                   pop;
  logic [`DRIVE_CH_W-1:0] ch_cnt;

  assign fifo_empty = (wr_ptr == rd_ptr);

  // The downstream path never stalls, so anything stored is popped at once.
  assign pop = !fifo_empty;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (din_valid) begin
      fifo_mem[wr_ptr[ptr_w-1:0]] <= din_entry;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (din_valid) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Each popped entry goes out with the next channel number in arrival
  // order, and the same pop hands one credit back to the host.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr          <= '0;
      ch_cnt          <= '0;
      credit_return   <= 1'b0;
      stage_a.valid   <= 1'b0;
      stage_a.channel <= '0;
      stage_a.entry   <= '0;
    end else begin
      credit_return <= pop;
      stage_a.valid <= pop;
      if (pop) begin
        rd_ptr          <= rd_ptr + 1'b1;
        stage_a.entry   <= fifo_mem[rd_ptr[ptr_w-1:0]];
        stage_a.channel <= ch_cnt;
        if (ch_cnt == `DRIVE_CH_W'(`DRIVE_NUM_CH - 1)) begin
          ch_cnt <= '0;
        end else begin
          ch_cnt <= ch_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/drive_stream_if.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "drive_macros.svh"

// Carries one entry per valid cycle between pipeline stages.
// There is no ready signal, so the sink must take every entry.
interface drive_stream_if #(
  parameter type payload_t = logic [2*`DRIVE_DATA_W-1:0]
) ();

  logic                   valid;
  logic [`DRIVE_CH_W-1:0] channel;
  payload_t               entry;

  modport source (
    output valid,
    output channel,
    output entry
  );

  modport sink (
    input valid,
    input channel,
    input entry
  );

endinterface

`default_nettype wire

// ==== source/drive_pkg.sv ====
`default_nettype none

`include "drive_macros.svh"

package drive_pkg;

  // One drive entry as streamed by the host.
  typedef struct packed {
    logic [`DRIVE_DATA_W-1:0] intensity;
    logic [`DRIVE_DATA_W-1:0] phase;
  } drive_entry_t;

  // Encoded entry handed to the PWM bank.
  typedef struct packed {
    logic [`DRIVE_DATA_W-1:0] pulse_width;
    logic [`DRIVE_DATA_W-1:0] phase;
  } pwm_entry_t;

endpackage

`default_nettype wire

// ==== source/drive_macros.svh ====
`ifndef DRIVE_MACROS_SVH
`define DRIVE_MACROS_SVH

// Number of transducer channels and the width of a channel index.
`define DRIVE_NUM_CH 8
`define DRIVE_CH_W 3

// Ingress FIFO entries, which is also the host's starting credit count.
`define DRIVE_FIFO_DEPTH 4

// Width of intensity, phase, pulse width and the time count.
`define DRIVE_DATA_W 8

`endif
